//--- Bender.yml
package:
  name: cpu_execute

sources:
  - files:
      - common/cpu_types_pkg.sv
      - common/execute_ops_pkg.sv
      - verilog/cpu_alu.sv
      - muldiv/cpu_multiply.sv
      - muldiv/cpu_divide.sv
      - execute/cpu_execute.sv
  - target: test
    files:
      - tb/tb_cpu_execute.sv

//--- common/cpu_types_pkg.sv
// ==============================
// Machine word and register types shared by every block of the core
// Import where word, product or register widths are needed
// ==============================

package cpu_types_pkg;

	localparam int WORD_BITS = 32;
	localparam int REG_BITS = 5;

	// Data word, PC and address
	typedef logic [WORD_BITS-1:0] word_t;

	// Full multiplier product
	typedef logic [2*WORD_BITS-1:0] dword_t;

	// Register index, zero means no writeback
	typedef logic [REG_BITS-1:0] register_t;

	localparam register_t REG_ZERO = '0;

	// Access width code, byte / half / word
	typedef logic [1:0] mem_width_t;

endpackage

//--- common/execute_ops_pkg.sv
// ==============================
// Encodings decoded by the execute stage
// Classes, ALU ops, operand selects, mul/div ops and unit latencies
// ==============================

package execute_ops_pkg;

	// Instruction class, codes above CLASS_COMPLEX are invalid
	typedef logic [2:0] op_class_t;
	localparam op_class_t CLASS_ARITH = 3'd0;
	localparam op_class_t CLASS_JUMP = 3'd1;
	localparam op_class_t CLASS_BRANCH = 3'd2;
	localparam op_class_t CLASS_LOAD = 3'd3;
	localparam op_class_t CLASS_STORE = 3'd4;
	localparam op_class_t CLASS_COMPLEX = 3'd5;

	// ALU operation, comparisons return 0 or 1
	typedef logic [3:0] alu_op_t;
	localparam alu_op_t ALU_ADD = 4'd0;
	localparam alu_op_t ALU_SUB = 4'd1;
	localparam alu_op_t ALU_SLL = 4'd2;
	localparam alu_op_t ALU_SLT = 4'd3;
	localparam alu_op_t ALU_SLTU = 4'd4;
	localparam alu_op_t ALU_XOR = 4'd5;
	localparam alu_op_t ALU_SRL = 4'd6;
	localparam alu_op_t ALU_SRA = 4'd7;
	localparam alu_op_t ALU_OR = 4'd8;
	localparam alu_op_t ALU_AND = 4'd9;
	localparam alu_op_t ALU_EQ = 4'd10;
	localparam alu_op_t ALU_NE = 4'd11;
	localparam alu_op_t ALU_LT = 4'd12;
	localparam alu_op_t ALU_GE = 4'd13;
	localparam alu_op_t ALU_LTU = 4'd14;
	localparam alu_op_t ALU_GEU = 4'd15;

	// One-hot operand source, bit positions
	typedef logic [4:0] operand_sel_t;
	localparam int SEL_ZERO = 0;
	localparam int SEL_RS1 = 1;
	localparam int SEL_RS2 = 2;
	localparam int SEL_PC = 3;
	localparam int SEL_IMM = 4;

	// Multiply / divide group
	typedef logic [2:0] complex_op_t;
	localparam complex_op_t OP_MUL = 3'd0;
	localparam complex_op_t OP_MULH = 3'd1;
	localparam complex_op_t OP_MULHU = 3'd2;
	localparam complex_op_t OP_DIV = 3'd3;
	localparam complex_op_t OP_DIVU = 3'd4;
	localparam complex_op_t OP_REM = 3'd5;
	localparam complex_op_t OP_REMU = 3'd6;

	// Cycles from unit latch to ready
	localparam int MUL_LATENCY = 3;
	localparam int DIV_LATENCY = 34;

endpackage

//--- cpu_execute.f
common/cpu_types_pkg.sv
common/execute_ops_pkg.sv
verilog/cpu_alu.sv
muldiv/cpu_multiply.sv
muldiv/cpu_divide.sv
execute/cpu_execute.sv
tb/tb_cpu_execute.sv

//--- execute/cpu_execute.sv
// ==============================
// Execute stage, sits between decode and memory
// Toggle strobe in, toggle strobe out, one instruction at a time
// ==============================

module cpu_execute
	import cpu_types_pkg::*;
	import execute_ops_pkg::*;
(
	input  logic         i_clock,
	input  logic         i_reset,

	// From decode
	input  logic         i_strobe,
	input  word_t        i_pc,
	input  word_t        i_imm,
	input  word_t        i_rs1,
	input  word_t        i_rs2,
	input  register_t    i_inst_rd,
	input  op_class_t    i_class,
	input  alu_op_t      i_alu_operation,
	input  operand_sel_t i_alu_operand1,
	input  operand_sel_t i_alu_operand2,
	input  complex_op_t  i_complex_op,
	input  mem_width_t   i_memory_width,
	input  logic         i_memory_signed,
	input  logic         i_memory_busy,

	// Control
	output logic         o_busy,
	output logic         o_fault,
	output logic         o_jump,
	output word_t        o_jump_pc,

	// To memory
	output logic         o_strobe,
	output word_t        o_pc,
	output word_t        o_rd,
	output register_t    o_inst_rd,
	output logic         o_mem_read,
	output logic         o_mem_write,
	output mem_width_t   o_mem_width,
	output logic         o_mem_signed,
	output word_t        o_mem_address
);

	typedef enum logic [1:0] {
		STATE_IDLE,
		STATE_WAIT_MUL,
		STATE_WAIT_DIV
	} complex_state_t;

	complex_state_t state;
	logic last_strobe;
	logic pending;
	logic accept;
	logic complex_done;
	logic complete;

	function automatic word_t select_operand(operand_sel_t sel, word_t rs1, word_t rs2,
		word_t pc, word_t imm);
		word_t value;
		value = '0;
		case (1'b1)
			sel[SEL_ZERO]: value = '0;
			sel[SEL_RS1]: value = rs1;
			sel[SEL_RS2]: value = rs2;
			sel[SEL_PC]: value = pc;
			sel[SEL_IMM]: value = imm;
			default: value = '0;
		endcase
		return value;
	endfunction

	// ==============================
	// ALU

	word_t alu_operand1;
	word_t alu_operand2;
	word_t alu_result;
	word_t alu_sum;

	assign alu_operand1 = select_operand(i_alu_operand1, i_rs1, i_rs2, i_pc, i_imm);
	assign alu_operand2 = select_operand(i_alu_operand2, i_rs1, i_rs2, i_pc, i_imm);

	cpu_alu alu (
		.i_op(i_alu_operation),
		.i_op1(alu_operand1),
		.i_op2(alu_operand2),
		.o_result(alu_result),
		.o_sum(alu_sum)
	);

	// ==============================
	// Multiply / divide

	logic mul_latch;
	logic mul_signed;
	logic mul_ready;
	dword_t mul_result;
	logic div_latch;
	logic div_signed;
	logic div_ready;
	word_t div_quotient;
	word_t div_remainder;
	logic is_mul_op;

	// Operands come straight from decode, which holds them until o_strobe
	assign is_mul_op = (i_complex_op == OP_MUL) || (i_complex_op == OP_MULH) ||
		(i_complex_op == OP_MULHU);
	assign mul_signed = (i_complex_op == OP_MULH);
	assign div_signed = (i_complex_op == OP_DIV) || (i_complex_op == OP_REM);

	cpu_multiply multiply (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_latch(mul_latch),
		.i_signed(mul_signed),
		.i_op1(i_rs1),
		.i_op2(i_rs2),
		.o_ready(mul_ready),
		.o_result(mul_result)
	);

	cpu_divide divide (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_latch(div_latch),
		.i_signed(div_signed),
		.i_numerator(i_rs1),
		.i_denominator(i_rs2),
		.o_ready(div_ready),
		.o_result(div_quotient),
		.o_remainder(div_remainder)
	);

	// ==============================
	// Dispatch

	word_t pc_plus4;
	word_t jump_target;
	word_t complex_result;
	word_t rd_value;

	assign pending = (i_strobe != last_strobe);
	assign accept = pending && !i_memory_busy;
	assign o_busy = pending && (i_class == CLASS_COMPLEX);
	assign pc_plus4 = i_pc + 32'd4;

	// Ready still shows the previous result while the latch pulse is out
	assign complex_done = accept && (i_class == CLASS_COMPLEX) &&
		(((state == STATE_WAIT_MUL) && !mul_latch && mul_ready) ||
		((state == STATE_WAIT_DIV) && !div_latch && div_ready));

	always_comb begin
		complete = complex_done;
		case (i_class)
			CLASS_ARITH, CLASS_JUMP, CLASS_BRANCH, CLASS_LOAD, CLASS_STORE: complete = accept;
			default: ;
		endcase
	end

	always_comb begin
		case (i_complex_op)
			OP_MUL: complex_result = mul_result[31:0];
			OP_MULH, OP_MULHU: complex_result = mul_result[63:32];
			OP_DIV, OP_DIVU: complex_result = div_quotient;
			default: complex_result = div_remainder;
		endcase
	end

	always_comb begin
		jump_target = alu_sum;
		// Branch comparison result lands in ALU bit 0
		if (i_class == CLASS_BRANCH) begin
			jump_target = alu_result[0] ? (i_pc + i_imm) : pc_plus4;
		end
	end

	always_comb begin
		case (i_class)
			CLASS_JUMP: rd_value = pc_plus4;
			CLASS_STORE: rd_value = i_rs2;
			CLASS_COMPLEX: rd_value = complex_result;
			default: rd_value = alu_result;
		endcase
	end

	// ==============================
	// Control state

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= STATE_IDLE;
			last_strobe <= 1'b0;
			o_strobe <= 1'b0;
			o_jump <= 1'b0;
			o_fault <= 1'b0;
			o_mem_read <= 1'b0;
			o_mem_write <= 1'b0;
			mul_latch <= 1'b0;
			div_latch <= 1'b0;
		end else begin
			o_jump <= 1'b0;
			mul_latch <= 1'b0;
			div_latch <= 1'b0;

			if (accept) begin
				case (i_class)
					CLASS_ARITH, CLASS_LOAD, CLASS_STORE: ;
					CLASS_JUMP, CLASS_BRANCH: o_jump <= 1'b1;
					CLASS_COMPLEX: begin
						if (state == STATE_IDLE) begin
							mul_latch <= is_mul_op;
							div_latch <= !is_mul_op;
							state <= is_mul_op ? STATE_WAIT_MUL : STATE_WAIT_DIV;
						end else if (complex_done) begin
							state <= STATE_IDLE;
						end
					end
					// Unknown class, stage stays stuck on it
					default: o_fault <= 1'b1;
				endcase
			end

			if (complete) begin
				last_strobe <= i_strobe;
				o_strobe <= ~o_strobe;
				o_mem_read <= (i_class == CLASS_LOAD);
				o_mem_write <= (i_class == CLASS_STORE);
			end
		end
	end

	// Result payload
	always_ff @(posedge i_clock) begin
		if (complete) begin
			o_pc <= i_pc;
			o_rd <= rd_value;
			o_inst_rd <= (i_class == CLASS_LOAD) ? REG_ZERO : i_inst_rd;
			o_jump_pc <= jump_target;
			o_mem_width <= i_memory_width;
			o_mem_signed <= i_memory_signed;
			o_mem_address <= alu_sum;
		end
	end

endmodule

//--- muldiv/cpu_divide.sv
// ==============================
// Iterative restoring divider, one quotient bit per cycle
// Pulse i_latch with operands, wait for o_ready
// ==============================

module cpu_divide
	import cpu_types_pkg::*;
	import execute_ops_pkg::*;
(
	input  logic  i_clock,
	input  logic  i_reset,
	input  logic  i_latch,
	input  logic  i_signed,
	input  word_t i_numerator,
	input  word_t i_denominator,
	output logic  o_ready,
	output word_t o_result,
	output word_t o_remainder
);

	// Zero when idle, 1..32 shift-subtract steps, last count fixes signs
	logic [5:0] cycle;
	word_t quotient_q;
	word_t remainder_q;
	word_t denominator_q;
	logic quotient_neg;
	logic remainder_neg;
	word_t numerator_abs;
	word_t denominator_abs;
	logic [32:0] trial;
	logic fix_step;

	assign numerator_abs = (i_signed && i_numerator[31]) ? -i_numerator : i_numerator;
	assign denominator_abs = (i_signed && i_denominator[31]) ? -i_denominator : i_denominator;
	assign trial = {remainder_q, quotient_q[31]} - {1'b0, denominator_q};
	assign fix_step = (cycle == 6'(DIV_LATENCY - 1));

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			cycle <= '0;
			o_ready <= 1'b0;
		end else if (i_latch) begin
			cycle <= 6'd1;
			o_ready <= 1'b0;
		end else if (fix_step) begin
			cycle <= '0;
			o_ready <= 1'b1;
		end else if (cycle != '0) begin
			cycle <= cycle + 6'd1;
		end
	end

	// Divide by zero falls out of the loop as all ones and the numerator,
	// as long as the quotient sign is left alone.
	// Most negative by minus one gives the numerator back the same way
	always_ff @(posedge i_clock) begin
		if (i_latch) begin
			quotient_q <= numerator_abs;
			remainder_q <= '0;
			denominator_q <= denominator_abs;
			quotient_neg <= i_signed && (i_numerator[31] ^ i_denominator[31]) &&
				(i_denominator != '0);
			remainder_neg <= i_signed && i_numerator[31];
		end else if (fix_step) begin
			o_result <= quotient_neg ? -quotient_q : quotient_q;
			o_remainder <= remainder_neg ? -remainder_q : remainder_q;
		end else if (cycle != '0) begin
			if (!trial[32]) begin
				remainder_q <= trial[31:0];
				quotient_q <= {quotient_q[30:0], 1'b1};
			end else begin
				// Restore, keep the shifted remainder
				remainder_q <= {remainder_q[30:0], quotient_q[31]};
				quotient_q <= {quotient_q[30:0], 1'b0};
			end
		end
	end

endmodule

//--- muldiv/cpu_multiply.sv
// ==============================
// Pipelined 32x32 multiplier, full 64-bit product
// Pulse i_latch with operands, result held once o_ready is high
// ==============================

module cpu_multiply
	import cpu_types_pkg::*;
	import execute_ops_pkg::*;
(
	input  logic   i_clock,
	input  logic   i_reset,
	input  logic   i_latch,
	input  logic   i_signed,
	input  word_t  i_op1,
	input  word_t  i_op2,
	output logic   o_ready,
	output dword_t o_result
);

	logic [MUL_LATENCY-1:0] valid;
	logic held;
	logic signed [32:0] op1_q;
	logic signed [32:0] op2_q;
	logic signed [49:0] part_lo;
	logic signed [49:0] part_hi;
	logic signed [65:0] product;

	// Upper half of op2 is weighted by 2^16
	assign product = (66'(part_hi) <<< 16) + 66'(part_lo);

	// Stays high until the next latch
	assign o_ready = valid[MUL_LATENCY-1] | held;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			valid <= '0;
			held <= 1'b0;
		end else begin
			valid <= {valid[MUL_LATENCY-2:0], i_latch};
			if (i_latch) begin
				held <= 1'b0;
			end else if (valid[MUL_LATENCY-1]) begin
				held <= 1'b1;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		// Extra top bit makes one signed multiply cover both modes
		if (i_latch) begin
			op1_q <= {i_signed & i_op1[31], i_op1};
			op2_q <= {i_signed & i_op2[31], i_op2};
		end
		if (valid[0]) begin
			part_lo <= op1_q * $signed({1'b0, op2_q[15:0]});
			part_hi <= op1_q * $signed(op2_q[32:16]);
		end
		if (valid[1]) begin
			o_result <= product[63:0];
		end
	end

endmodule

//--- tb/tb_cpu_execute.sv
// ==============================
// Self-checking testbench for the execute stage
// Reference model, toggle-strobe driver, compare process and timeout
// ==============================

module tb_cpu_execute
	import cpu_types_pkg::*;
	import execute_ops_pkg::*;
();

	// Test counts that also size the timeout
	localparam int N_ARITH = 200;
	localparam int N_JUMP = 4;
	localparam int N_BRANCH = 18;
	localparam int N_MEM = 8;
	localparam int N_COMPLEX_RAND = 42;
	localparam int N_COMPLEX_FIXED = 10;
	localparam int N_SIMPLE = N_ARITH + N_JUMP + N_BRANCH + N_MEM + 2;
	localparam int N_COMPLEX = N_COMPLEX_RAND + N_COMPLEX_FIXED + 1;
	localparam int CYCLE_LIMIT = N_COMPLEX * (DIV_LATENCY + 4) + N_SIMPLE * 4 + 100;

	localparam operand_sel_t PICK_RS1 = 5'(1 << SEL_RS1);
	localparam operand_sel_t PICK_RS2 = 5'(1 << SEL_RS2);
	localparam operand_sel_t PICK_PC = 5'(1 << SEL_PC);
	localparam operand_sel_t PICK_IMM = 5'(1 << SEL_IMM);

	typedef struct packed {
		word_t rd;
		logic check_rd;
		register_t inst_rd;
		logic jump;
		word_t jump_pc;
		logic mem_read;
		logic mem_write;
		word_t mem_address;
	} result_t;

	logic i_clock;
	logic i_reset;
	logic i_strobe;
	word_t i_pc;
	word_t i_imm;
	word_t i_rs1;
	word_t i_rs2;
	register_t i_inst_rd;
	op_class_t i_class;
	alu_op_t i_alu_operation;
	operand_sel_t i_alu_operand1;
	operand_sel_t i_alu_operand2;
	complex_op_t i_complex_op;
	mem_width_t i_memory_width;
	logic i_memory_signed;
	logic i_memory_busy;
	logic o_busy;
	logic o_fault;
	logic o_jump;
	word_t o_jump_pc;
	logic o_strobe;
	word_t o_pc;
	word_t o_rd;
	register_t o_inst_rd;
	logic o_mem_read;
	logic o_mem_write;
	mem_width_t o_mem_width;
	logic o_mem_signed;
	word_t o_mem_address;

	// Shared between driver and compare process
	result_t model_out;
	string test_name;
	mem_width_t cur_width;
	logic cur_sign;
	word_t cur_pc;
	logic armed;
	logic seen_strobe;
	int done_count;
	int test_errors;
	int tests_passed;
	int tests_failed;
	int stray_errors;
	int cycle_count;

	cpu_execute i_dut (.*);

	always #4 i_clock = ~i_clock;

	// ==============================
	// Reference model

	function automatic word_t pick_operand(operand_sel_t sel, word_t rs1, word_t rs2,
		word_t pc, word_t imm);
		if (sel[SEL_RS1])
			return rs1;
		else if (sel[SEL_RS2])
			return rs2;
		else if (sel[SEL_PC])
			return pc;
		else if (sel[SEL_IMM])
			return imm;
		return '0;
	endfunction

	function automatic word_t alu_model(alu_op_t op, word_t a, word_t b);
		case (op)
			ALU_ADD: return a + b;
			ALU_SUB: return a - b;
			ALU_SLL: return a << b[4:0];
			ALU_SLT, ALU_LT: return {31'd0, $signed(a) < $signed(b)};
			ALU_SLTU, ALU_LTU: return {31'd0, a < b};
			ALU_XOR: return a ^ b;
			ALU_SRL: return a >> b[4:0];
			ALU_SRA: return $signed(a) >>> b[4:0];
			ALU_OR: return a | b;
			ALU_AND: return a & b;
			ALU_EQ: return {31'd0, a == b};
			ALU_NE: return {31'd0, a != b};
			ALU_GE: return {31'd0, $signed(a) >= $signed(b)};
			default: return {31'd0, a >= b};
		endcase
	endfunction

	// RISC-V rules for the M group including divide by zero and overflow
	function automatic word_t complex_model(complex_op_t op, word_t a, word_t b);
		logic signed [63:0] sa;
		logic signed [63:0] sb;
		logic signed [31:0] quot_s;
		logic signed [31:0] rem_s;
		logic [63:0] product;
		logic overflow;
		sa = {{32{a[31]}}, a};
		sb = {{32{b[31]}}, b};
		overflow = (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF);
		quot_s = '0;
		rem_s = '0;
		// Regular signed case, truncating toward zero
		if ((b != 0) && !overflow) begin
			quot_s = $signed(a) / $signed(b);
			rem_s = $signed(a) % $signed(b);
		end
		case (op)
			OP_MUL: product = {32'd0, a} * {32'd0, b};
			OP_MULH: product = sa * sb;
			OP_MULHU: product = {32'd0, a} * {32'd0, b};
			default: product = '0;
		endcase
		case (op)
			OP_MUL: return product[31:0];
			OP_MULH, OP_MULHU: return product[63:32];
			OP_DIV: return (b == 0) ? '1 : (overflow ? a : quot_s);
			OP_DIVU: return (b == 0) ? '1 : a / b;
			OP_REM: return (b == 0) ? a : (overflow ? '0 : rem_s);
			default: return (b == 0) ? a : a % b;
		endcase
	endfunction

	function automatic result_t exec_model(op_class_t cls, alu_op_t op, operand_sel_t sel1,
		operand_sel_t sel2, complex_op_t cop, word_t pc, word_t imm, word_t rs1,
		word_t rs2, register_t rd);
		result_t r;
		word_t a;
		word_t b;
		word_t cmp;
		a = pick_operand(sel1, rs1, rs2, pc, imm);
		b = pick_operand(sel2, rs1, rs2, pc, imm);
		cmp = alu_model(op, a, b);
		r = '0;
		r.check_rd = 1'b1;
		r.inst_rd = rd;
		r.mem_address = a + b;
		case (cls)
			CLASS_ARITH: r.rd = cmp;
			CLASS_JUMP: begin
				r.rd = pc + 4;
				r.jump = 1'b1;
				r.jump_pc = a + b;
			end
			CLASS_BRANCH: begin
				r.check_rd = 1'b0;
				r.jump = 1'b1;
				r.jump_pc = cmp[0] ? pc + imm : pc + 4;
			end
			CLASS_LOAD: begin
				r.check_rd = 1'b0;
				r.inst_rd = '0;
				r.mem_read = 1'b1;
			end
			CLASS_STORE: begin
				r.rd = rs2;
				r.mem_write = 1'b1;
			end
			default: r.rd = complex_model(cop, rs1, rs2);
		endcase
		return r;
	endfunction

	// ==============================
	// Compare tasks and process

	task automatic check_word(input string field, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			$display("MISMATCH %s %s expected %h actual %h", test_name, field, expected, actual);
			test_errors++;
		end
	endtask

	task automatic check_reg(input string field, input register_t expected,
		input register_t actual);
		if (actual !== expected) begin
			$display("MISMATCH %s %s expected %0d actual %0d", test_name, field, expected,
				actual);
			test_errors++;
		end
	endtask

	task automatic check_width(input string field, input mem_width_t expected,
		input mem_width_t actual);
		if (actual !== expected) begin
			$display("MISMATCH %s %s expected %0d actual %0d", test_name, field, expected,
				actual);
			test_errors++;
		end
	endtask

	task automatic check_flag(input string field, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("MISMATCH %s %s expected %b actual %b", test_name, field, expected, actual);
			test_errors++;
		end
	endtask

	// Outputs settle at the rising edge and are sampled half a cycle later
	always @(negedge i_clock) begin
		if (!i_reset && (o_strobe !== seen_strobe)) begin
			seen_strobe = o_strobe;
			if (!armed) begin
				$display("Output strobe toggled with no instruction outstanding");
				stray_errors++;
			end else begin
				if (model_out.check_rd)
					check_word("o_rd", model_out.rd, o_rd);
				check_reg("o_inst_rd", model_out.inst_rd, o_inst_rd);
				check_word("o_pc", cur_pc, o_pc);
				check_flag("o_jump", model_out.jump, o_jump);
				if (model_out.jump)
					check_word("o_jump_pc", model_out.jump_pc, o_jump_pc);
				check_flag("o_mem_read", model_out.mem_read, o_mem_read);
				check_flag("o_mem_write", model_out.mem_write, o_mem_write);
				if (model_out.mem_read || model_out.mem_write) begin
					check_word("o_mem_address", model_out.mem_address, o_mem_address);
					check_width("o_mem_width", cur_width, o_mem_width);
					check_flag("o_mem_signed", cur_sign, o_mem_signed);
				end
				armed = 1'b0;
				done_count++;
			end
		end
	end

	always @(posedge i_clock) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles in test %s", cycle_count, test_name);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// ==============================
	// Driver

	function automatic operand_sel_t random_select();
		return operand_sel_t'(1) << ($urandom % 5);
	endfunction

	task automatic finish_test();
		if (test_errors == 0) begin
			$display("PASS %s", test_name);
			tests_passed++;
		end else begin
			$display("FAIL %s (%0d errors)", test_name, test_errors);
			tests_failed++;
		end
	endtask

	// Memory back-pressure for hold_busy cycles, starting busy_delay cycles after issue
	task automatic send_instruction(input string name, input op_class_t cls, input alu_op_t op,
		input operand_sel_t sel1, input operand_sel_t sel2, input complex_op_t cop,
		input word_t pc, input word_t imm, input word_t rs1, input word_t rs2,
		input register_t rd, input mem_width_t width, input logic sign,
		input int hold_busy, input int busy_delay);
		int start_count;
		logic strobe_snap;
		word_t rd_snap;
		test_name = name;
		test_errors = 0;
		model_out = exec_model(cls, op, sel1, sel2, cop, pc, imm, rs1, rs2, rd);
		cur_width = width;
		cur_sign = sign;
		cur_pc = pc;
		start_count = done_count;
		armed = 1'b1;
		@(posedge i_clock);
		i_class <= cls;
		i_alu_operation <= op;
		i_alu_operand1 <= sel1;
		i_alu_operand2 <= sel2;
		i_complex_op <= cop;
		i_pc <= pc;
		i_imm <= imm;
		i_rs1 <= rs1;
		i_rs2 <= rs2;
		i_inst_rd <= rd;
		i_memory_width <= width;
		i_memory_signed <= sign;
		i_memory_busy <= (hold_busy > 0) && (busy_delay == 0);
		i_strobe <= ~i_strobe;
		if (cls == CLASS_COMPLEX) begin
			@(negedge i_clock);
			check_flag("o_busy", 1'b1, o_busy);
		end else if (hold_busy == 0) begin
			// Simple classes finish on the first edge after issue
			@(negedge i_clock);
			strobe_snap = o_strobe;
			@(negedge i_clock);
			if (o_strobe === strobe_snap) begin
				$display("%s: no completion one cycle after issue", name);
				test_errors++;
			end
		end
		if (hold_busy > 0) begin
			if (busy_delay > 0) begin
				repeat (busy_delay) @(posedge i_clock);
				i_memory_busy <= 1'b1;
			end
			@(negedge i_clock);
			strobe_snap = o_strobe;
			rd_snap = o_rd;
			repeat (hold_busy) begin
				@(negedge i_clock);
				if ((o_strobe !== strobe_snap) || (o_rd !== rd_snap)) begin
					$display("%s: outputs changed while memory was busy", name);
					test_errors++;
				end
			end
			@(posedge i_clock);
			i_memory_busy <= 1'b0;
		end
		wait (done_count != start_count);
		if (hold_busy > 0) begin
			repeat (3) @(negedge i_clock);
			if (done_count != start_count + 1) begin
				$display("%s: expected one completion after release, saw %0d", name,
					done_count - start_count);
				test_errors++;
			end
		end
		finish_test();
	endtask

	task automatic run_complex(input string name, input complex_op_t cop, input word_t a,
		input word_t b);
		send_instruction(name, CLASS_COMPLEX, ALU_ADD, PICK_RS1, PICK_RS2, cop, 32'h100,
			'0, a, b, register_t'($urandom), 2'd0, 1'b0, 0, 0);
	endtask

	// ==============================
	// Test sequence

	word_t branch_a [3];
	word_t branch_b [3];

	initial begin
		void'($urandom(43156));
		i_clock = 1'b0;
		i_reset = 1'b1;
		i_strobe = 1'b0;
		i_pc = '0;
		i_imm = '0;
		i_rs1 = '0;
		i_rs2 = '0;
		i_inst_rd = '0;
		i_class = CLASS_ARITH;
		i_alu_operation = ALU_ADD;
		i_alu_operand1 = PICK_RS1;
		i_alu_operand2 = PICK_RS2;
		i_complex_op = OP_MUL;
		i_memory_width = '0;
		i_memory_signed = 1'b0;
		i_memory_busy = 1'b0;
		armed = 1'b0;
		seen_strobe = 1'b0;
		done_count = 0;
		test_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		stray_errors = 0;
		cycle_count = 0;
		test_name = "reset";
		// Equal, negative against positive, and the reverse
		branch_a[0] = 32'd5;
		branch_b[0] = 32'd5;
		branch_a[1] = 32'hFFFF_FFFD;
		branch_b[1] = 32'd2;
		branch_a[2] = 32'd2;
		branch_b[2] = 32'hFFFF_FFFD;
		repeat (8) @(posedge i_clock);
		i_reset <= 1'b0;

		for (int i = 0; i < N_ARITH; i++) begin
			send_instruction($sformatf("arith_%0d", i), CLASS_ARITH, alu_op_t'($urandom % 16),
				random_select(), random_select(), OP_MUL, $urandom & 32'hFFFF_FFFC, $urandom,
				$urandom, $urandom, register_t'($urandom), 2'd0, 1'b0, 0, 0);
		end

		// Alternate pc-relative and register-relative jumps
		for (int i = 0; i < N_JUMP; i++) begin
			send_instruction($sformatf("jump_%0d", i), CLASS_JUMP, ALU_ADD,
				(i % 2) ? PICK_RS1 : PICK_PC, PICK_IMM, OP_MUL, $urandom & 32'hFFFF_FFFC,
				$urandom, $urandom, $urandom, register_t'($urandom), 2'd0, 1'b0, 0, 0);
		end

		for (int op = ALU_EQ; op <= ALU_GEU; op++) begin
			for (int p = 0; p < 3; p++) begin
				send_instruction($sformatf("branch_op%0d_pair%0d", op, p), CLASS_BRANCH,
					alu_op_t'(op), PICK_RS1, PICK_RS2, OP_MUL, $urandom & 32'hFFFF_FFFC,
					$urandom & 32'h0000_0FFE, branch_a[p], branch_b[p], 5'd0, 2'd0, 1'b0, 0, 0);
			end
		end

		for (int i = 0; i < N_MEM; i++) begin
			send_instruction((i % 2) ? $sformatf("store_%0d", i) : $sformatf("load_%0d", i),
				(i % 2) ? CLASS_STORE : CLASS_LOAD, ALU_ADD, PICK_RS1, PICK_IMM, OP_MUL,
				$urandom & 32'hFFFF_FFFC, $urandom & 32'h0000_0FFF, $urandom, $urandom,
				register_t'($urandom | 1), mem_width_t'(i % 3), 1'($urandom), 0, 0);
		end

		for (int c = OP_MUL; c <= OP_REMU; c++) begin
			for (int k = 0; k < N_COMPLEX_RAND / 7; k++) begin
				run_complex($sformatf("complex_op%0d_%0d", c, k), complex_op_t'(c), $urandom,
					(k == 0) ? ($urandom % 16) + 1 : $urandom);
			end
		end

		run_complex("div_by_zero", OP_DIV, 32'hFFFF_FF85, 32'd0);
		run_complex("divu_by_zero", OP_DIVU, 32'h1234_5678, 32'd0);
		run_complex("rem_by_zero", OP_REM, 32'hFFFF_FF85, 32'd0);
		run_complex("remu_by_zero", OP_REMU, 32'h8765_4321, 32'd0);
		run_complex("div_overflow", OP_DIV, 32'h8000_0000, 32'hFFFF_FFFF);
		run_complex("rem_overflow", OP_REM, 32'h8000_0000, 32'hFFFF_FFFF);
		run_complex("rem_neg_num", OP_REM, 32'hFFFF_FFF9, 32'd2);
		run_complex("rem_neg_den", OP_REM, 32'd7, 32'hFFFF_FFFE);
		run_complex("mulh_neg_neg", OP_MULH, 32'h8000_0000, 32'h8000_0000);
		run_complex("mulhu_max", OP_MULHU, 32'hFFFF_FFFF, 32'hFFFF_FFFF);

		// Busy from issue on a simple op and then over a running divide
		send_instruction("backpressure_arith", CLASS_ARITH, ALU_XOR, PICK_RS1, PICK_IMM,
			OP_MUL, 32'h200, 32'h00FF_00FF, 32'h1357_9BDF, 32'd0, 5'd9, 2'd0, 1'b0, 5, 0);
		send_instruction("backpressure_div", CLASS_COMPLEX, ALU_ADD, PICK_RS1, PICK_RS2,
			OP_DIV, 32'h204, 32'd0, 32'hFFFF_F000, 32'd7, 5'd11, 2'd0, 1'b0,
			DIV_LATENCY + 6, 2);

		// Invalid class leaves the stage stuck and must come last
		test_name = "fault_invalid_class";
		test_errors = 0;
		@(posedge i_clock);
		i_class <= op_class_t'(3'd7);
		i_strobe <= ~i_strobe;
		repeat (3) @(negedge i_clock);
		if (o_fault !== 1'b1) begin
			$display("Fault flag did not rise after an invalid instruction class");
			test_errors++;
		end
		repeat (5) @(negedge i_clock);
		if (o_fault !== 1'b1) begin
			$display("Fault flag dropped before reset");
			test_errors++;
		end
		finish_test();

		$display("Tests passed %0d, failed %0d, stray completions %0d", tests_passed,
			tests_failed, stray_errors);
		if ((tests_failed == 0) && (stray_errors == 0)) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

//--- verilog/cpu_alu.sv
// ==============================
// Combinational integer ALU
// Also gives the plain sum for address and jump targets
// ==============================

module cpu_alu
	import cpu_types_pkg::*;
	import execute_ops_pkg::*;
(
	input  alu_op_t i_op,
	input  word_t   i_op1,
	input  word_t   i_op2,
	output word_t   o_result,
	output word_t   o_sum
);

	logic [4:0] shamt;

	assign shamt = i_op2[4:0];

	// Wraps on overflow, same as the hardware address adder
	assign o_sum = i_op1 + i_op2;

	always_comb begin
		o_result = '0;
		case (i_op)
			ALU_ADD: o_result = o_sum;
			ALU_SUB: o_result = i_op1 - i_op2;
			ALU_SLL: o_result = i_op1 << shamt;
			ALU_SLT: o_result = word_t'($signed(i_op1) < $signed(i_op2));
			ALU_SLTU: o_result = word_t'(i_op1 < i_op2);
			ALU_XOR: o_result = i_op1 ^ i_op2;
			ALU_SRL: o_result = i_op1 >> shamt;
			ALU_SRA: o_result = word_t'($signed(i_op1) >>> shamt);
			ALU_OR: o_result = i_op1 | i_op2;
			ALU_AND: o_result = i_op1 & i_op2;
			// Branch compares
			ALU_EQ: o_result = word_t'(i_op1 == i_op2);
			ALU_NE: o_result = word_t'(i_op1 != i_op2);
			ALU_LT: o_result = word_t'($signed(i_op1) < $signed(i_op2));
			ALU_GE: o_result = word_t'($signed(i_op1) >= $signed(i_op2));
			ALU_LTU: o_result = word_t'(i_op1 < i_op2);
			ALU_GEU: o_result = word_t'(i_op1 >= i_op2);
			default: o_result = '0;
		endcase
	end

endmodule
